// ==== spi_link.f ====
verilog/spi_link_pkg.sv
verilog/spi_master.sv
verilog/spi_slave_driver.sv
verilog/spi_reg_device.sv
verilog/spi_link.sv
test/spi_link_checker.sv
test/spi_link_tb.sv

// ==== test/spi_link_tb.sv ====
module spi_link_tb;
  import spi_link_pkg::*;

  localparam int div_width   = 8;
  localparam int ack_timeout = 20;  // clocks
  localparam int idle_polls  = 400; // status reads
  localparam int num_entries = 8;
  localparam int num_random  = 20;

  typedef struct {
    string       name;
    logic [15:0] word;   // frame sent to the device
    logic [15:0] exp_rx; // rxdata expected back during this frame
  } entry_t;

  logic    rst;
  logic    clk;
  wb_req_t wb_req;
  wb_rsp_t wb_rsp;

  logic [31:0] lfsr_q;
  logic [11:0] model_regs [8];
  spi_frame_u  model_reply;
  int          pass_polls [3];
  int          pass_div [3] = '{4, 1, 9};

  // writes to four registers, then reads back with the reply lagging one frame
  entry_t vectors [num_entries] = '{
    '{"wr_a0",      16'h8123, 16'h505a},
    '{"wr_a3",      16'hbabc, 16'h8123},
    '{"wr_a7",      16'hffff, 16'hbabc},
    '{"wr_a5",      16'hd05a, 16'hffff},
    '{"rd_a3",      16'h3000, 16'hd05a},
    '{"rd_a7",      16'h7000, 16'h3abc},
    '{"rd_a0",      16'h0000, 16'h7fff},
    '{"rd_a5_junk", 16'h5e0f, 16'h0123}  // data bits of a read are ignored
  };

  spi_link #(
    .div_width (div_width)
  ) u_spi_link (
    .rst    (rst),
    .clk    (clk),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp)
  );

  always #5 rst = ~rst;

  ////////////////////////////////////////////////////////////////////////////
  // reporting and compare

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("SOME TESTS FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_frame(input string name, input spi_frame_u exp, input spi_frame_u act);
    if (act.raw !== exp.raw)
      fail_run($sformatf("error %s: expected %h, actual %h", name, exp.raw, act.raw));
  endtask

  task automatic check_status(input string name, input logic exp, input logic act);
    if (act !== exp)
      fail_run($sformatf("error %s: expected busy %b, actual %b", name, exp, act));
  endtask

  task automatic check_word(input string name, input logic [15:0] exp, input logic [15:0] act);
    if (act !== exp)
      fail_run($sformatf("error %s: expected %h, actual %h", name, exp, act));
  endtask

  // galois form stepped once per bit taken
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [15:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits   = {bits[14:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // host bus tasks

  task automatic wb_cycle(input logic we, input logic [1:0] adr, input logic [15:0] dat,
                          output logic [15:0] rdat);
    int waited;
    waited = 0;
    @(negedge rst);
    wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
    while (!wb_rsp.ack) begin
      if (waited == ack_timeout)
        fail_run("no Wishbone ack arrived in time");
      @(negedge rst);
      waited++;
    end
    if (waited != 1)
      fail_run("Wishbone ack did not come one clock after the cycle opened");
    rdat = wb_rsp.dat;
    @(negedge rst); // keep cyc up across the edge that samples ack
    wb_req = '0;
  endtask

  task automatic wb_write(input logic [1:0] adr, input logic [15:0] dat);
    logic [15:0] unused;
    wb_cycle(1'b1, adr, dat, unused);
  endtask

  task automatic wb_read(input logic [1:0] adr, output logic [15:0] dat);
    wb_cycle(1'b0, adr, '0, dat);
  endtask

  task automatic wait_idle(output int polls);
    logic [15:0] status;
    polls = 0;
    wb_read(reg_status, status);
    while (status[0]) begin
      if (polls == idle_polls)
        fail_run("busy never cleared after a frame was started");
      wb_read(reg_status, status);
      polls++;
    end
  endtask

  task automatic set_div(input logic [15:0] div);
    logic [15:0] rd;
    wb_write(reg_clkdiv, div);
    wb_read(reg_clkdiv, rd);
    check_word($sformatf("clkdiv_%0d", div), div, rd);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // reference model of the device

  // returns what the device sends back during this frame, then applies it
  task automatic model_frame(input spi_frame_u sent, output spi_frame_u exp_rx);
    exp_rx = model_reply;
    if (sent.cmd.write) begin
      model_regs[sent.cmd.addr] = sent.cmd.data;
      model_reply = sent;
    end else begin
      model_reply.cmd.write = 1'b0;
      model_reply.cmd.addr  = sent.cmd.addr;
      model_reply.cmd.data  = model_regs[sent.cmd.addr];
    end
  endtask

  task automatic run_frame(input string name, input logic [15:0] word,
                           output spi_frame_u got, output int polls);
    spi_frame_u  sent;
    spi_frame_u  exp_rx;
    logic [15:0] rd;
    sent.raw = word;
    model_frame(sent, exp_rx);
    wb_write(reg_txdata, word);
    wait_idle(polls);
    wb_read(reg_rxdata, rd);
    got.raw = rd;
    check_frame(name, exp_rx, got);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence

  initial begin
    spi_frame_u  got;
    spi_frame_u  exp_tab;
    spi_frame_u  sent;
    spi_frame_u  exp_rx;
    logic [15:0] rd;
    logic [15:0] word;
    logic [15:0] div_bits;
    int          polls;
    rst         = 1'b0;
    clk         = 1'b1;
    wb_req      = '0;
    lfsr_q      = 32'hb046;
    model_reply = '0;
    for (int i = 0; i < 8; i++)
      model_regs[i] = '0;
    repeat (10) @(negedge rst);
    clk = 1'b0;

    wb_read(reg_status, rd);
    check_status("reset_busy", 1'b0, rd[0]);
    wb_read(reg_clkdiv, rd);
    check_word("reset_clkdiv", 16'(clkdiv_reset), rd);
    run_frame("first_frame", 16'hd05a, got, polls);
    exp_tab.raw = 16'h0000; // reply word is still at its reset value
    check_frame("first_frame_zero", exp_tab, got);
    run_frame("prime_rd_a5", 16'h5000, got, polls);

    // same table at three dividers, so the rxdata column never changes
    for (int p = 0; p < 3; p++) begin
      set_div(16'(pass_div[p]));
      pass_polls[p] = 0;
      for (int i = 0; i < num_entries; i++) begin
        run_frame(vectors[i].name, vectors[i].word, got, polls);
        exp_tab.raw = vectors[i].exp_rx;
        check_frame({vectors[i].name, "_table"}, exp_tab, got);
        pass_polls[p] += polls;
      end
    end
    // passes ran at dividers 4, 1 and 9
    if (pass_polls[1] >= pass_polls[0] || pass_polls[0] >= pass_polls[2])
      fail_run("busy period did not grow with the divider");

    // a second txdata write during a frame must be dropped
    sent.raw = 16'h9321;
    model_frame(sent, exp_rx);
    wb_write(reg_txdata, sent.raw);
    wb_read(reg_status, rd);
    check_status("busy_after_start", 1'b1, rd[0]);
    wb_write(reg_txdata, 16'ha777);
    wb_read(reg_status, rd);
    check_status("busy_after_drop", 1'b1, rd[0]);
    wait_idle(polls);
    wb_read(reg_rxdata, rd);
    got.raw = rd;
    check_frame("busy_frame", exp_rx, got);
    run_frame("after_drop_rd_a2", 16'h2000, got, polls);
    run_frame("after_drop_rd_a1", 16'h1000, got, polls);

    for (int i = 0; i < num_random; i++) begin
      take_bits(2, div_bits);
      set_div(div_bits + 16'd1);
      take_bits(16, word);
      run_frame($sformatf("random_%0d", i), word, got, polls);
    end

    set_div(16'h005a);
    set_div(16'h0000); // runs like a divider of 1
    run_frame("div_zero_frame", 16'hc5a5, got, polls);
    run_frame("div_zero_rd_a4", 16'h4000, got, polls);

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// ==== test/spi_link_checker.sv ====
module spi_link_checker (
  input logic                   rst,
  input logic                   clk,
  input spi_link_pkg::wb_req_t  wb_req,
  input spi_link_pkg::wb_rsp_t  wb_rsp,
  input spi_link_pkg::spi_bus_t spi,
  input logic                   rx_valid
);

  ////////////////////////////////////////////////////////////////////////////
  // wishbone side

  ack_one_cycle: assert property (@(posedge rst) disable iff (clk)
    wb_rsp.ack |=> !wb_rsp.ack)
    else $error("ack stayed high for more than one cycle");

  // the host holds the cycle open through the edge that sees ack
  ack_in_cycle: assert property (@(posedge rst) disable iff (clk)
    wb_rsp.ack |-> (wb_req.cyc && wb_req.stb))
    else $error("ack seen outside an open bus cycle");

  ////////////////////////////////////////////////////////////////////////////
  // spi side

  sclk_idle_low: assert property (@(posedge rst) disable iff (clk)
    spi.cs |-> !spi.sclk)
    else $error("sclk high while cs is deasserted");

  // synchronizer delay lets rx_valid trail the cs rise a little
  rx_valid_in_frame: assert property (@(posedge rst) disable iff (clk)
    rx_valid |-> (!spi.cs || $past(!spi.cs, 1) || $past(!spi.cs, 2)))
    else $error("rx_valid outside a frame");

endmodule

bind spi_link spi_link_checker u_spi_link_checker (
  .rst      (rst),
  .clk      (clk),
  .wb_req   (wb_req),
  .wb_rsp   (wb_rsp),
  .spi      (spi),
  .rx_valid (rx_valid)
);

// ==== verilog/spi_link.sv ====
module spi_link #(
  parameter int div_width = 8 // sclk divider counter width
) (
  input  logic                  rst,
  input  logic                  clk,
  input  spi_link_pkg::wb_req_t wb_req,
  output spi_link_pkg::wb_rsp_t wb_rsp
);
  import spi_link_pkg::*;

  spi_bus_t   spi;
  logic       miso;
  spi_frame_u rx_frame;
  spi_frame_u tx_frame;
  logic       rx_valid;

  ////////////////////////////////////////////////////////////////////////////
  // host side

  spi_master #(
    .div_width (div_width)
  ) u_spi_master (
    .rst    (rst),
    .clk    (clk),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp),
    .spi    (spi),
    .miso   (miso)
  );

  ////////////////////////////////////////////////////////////////////////////
  // device side

  spi_slave_driver u_spi_slave_driver (
    .rst      (rst),
    .clk      (clk),
    .spi      (spi),
    .miso     (miso),
    .tx_frame (tx_frame),
    .rx_frame (rx_frame),
    .rx_valid (rx_valid)
  );

  spi_reg_device u_spi_reg_device (
    .rst      (rst),
    .clk      (clk),
    .rx_frame (rx_frame),
    .rx_valid (rx_valid),
    .tx_frame (tx_frame)
  );

endmodule

// ==== verilog/spi_reg_device.sv ====
module spi_reg_device (
  input  logic                     rst,
  input  logic                     clk,
  input  spi_link_pkg::spi_frame_u rx_frame,
  input  logic                     rx_valid,
  output spi_link_pkg::spi_frame_u tx_frame
);
  import spi_link_pkg::*;

  localparam int num_regs = 2 ** cmd_addr_width;

  logic [cmd_data_width-1:0] regs [num_regs];
  spi_cmd_t                  cmd;
  spi_cmd_t                  reply;

  ////////////////////////////////////////////////////////////////////////////
  // command decode

  assign cmd = rx_frame.cmd;

  // a write echoes itself, a read returns the register
  always_comb begin
    reply = cmd;
    if (!cmd.write)
      reply.data = regs[cmd.addr];
  end

  ////////////////////////////////////////////////////////////////////////////
  // register file and reply word

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      for (int i = 0; i < num_regs; i++)
        regs[i] <= '0;
      tx_frame <= '0;
    end else if (rx_valid) begin
      if (cmd.write)
        regs[cmd.addr] <= cmd.data;
      tx_frame.cmd <= reply; // sent back during the next frame
    end
  end

endmodule

// ==== verilog/spi_slave_driver.sv ====
module spi_slave_driver (
  input  logic                     rst,
  input  logic                     clk,
  input  spi_link_pkg::spi_bus_t   spi,
  output logic                     miso,
  input  spi_link_pkg::spi_frame_u tx_frame,
  output spi_link_pkg::spi_frame_u rx_frame,
  output logic                     rx_valid
);
  import spi_link_pkg::*;

  localparam int cnt_width = $clog2(frame_width);

  localparam logic [1:0] st_idle      = 2'd0; // wait for cs low
  localparam logic [1:0] st_wait_high = 2'd1;
  localparam logic [1:0] st_wait_low  = 2'd2;

  spi_bus_t               spi_q;
  logic [1:0]             state;
  logic [cnt_width-1:0]   bit_cnt;
  logic [frame_width-1:0] shift_q;
  logic                   frame_done;

  // whole bus goes through one stage so sclk, cs and mosi stay aligned
  always_ff @(posedge rst or posedge clk) begin
    if (clk)
      spi_q <= '{sclk: 1'b0, cs: 1'b1, mosi: 1'b0};
    else
      spi_q <= spi;
  end

  // counter wrapped to 0 means every bit has seen its rise
  assign frame_done = (state == st_wait_low) && !spi_q.cs && !spi_q.sclk
                      && (bit_cnt == '0);

  ////////////////////////////////////////////////////////////////////////////
  // shifter

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      state    <= st_idle;
      bit_cnt  <= '0;
      shift_q  <= '0;
      miso     <= 1'b0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= frame_done;
      if (spi_q.cs) begin
        bit_cnt <= '0;
        state   <= st_idle;
      end else begin
        case (state)
          st_idle: begin
            shift_q <= tx_frame.raw; // reply word for this frame
            bit_cnt <= '0;
            state   <= st_wait_high;
          end
          st_wait_high: begin
            if (spi_q.sclk) begin
              miso    <= shift_q[frame_width-1];
              bit_cnt <= bit_cnt + 1'b1;
              state   <= st_wait_low;
            end
          end
          st_wait_low: begin
            if (!spi_q.sclk) begin
              if (bit_cnt == '0)
                shift_q <= tx_frame.raw; // reload for a following frame
              else
                shift_q <= {shift_q[frame_width-2:0], spi_q.mosi};
              state <= st_wait_high;
            end
          end
          default: state <= st_idle;
        endcase
      end
    end
  end

  always_ff @(posedge rst) begin
    if (frame_done)
      rx_frame.raw <= {shift_q[frame_width-2:0], spi_q.mosi};
  end

endmodule

// ==== verilog/spi_master.sv ====
module spi_master #(
  parameter int div_width = 8
) (
  input  logic                    rst,
  input  logic                    clk,
  input  spi_link_pkg::wb_req_t   wb_req,
  output spi_link_pkg::wb_rsp_t   wb_rsp,
  output spi_link_pkg::spi_bus_t  spi,
  input  logic                    miso
);
  import spi_link_pkg::*;

  localparam int bit_cnt_width = $clog2(frame_width);

  localparam logic [2:0] st_idle  = 3'd0;
  localparam logic [2:0] st_lead  = 3'd1; // cs low, sclk not yet risen
  localparam logic [2:0] st_high  = 3'd2;
  localparam logic [2:0] st_low   = 3'd3;
  localparam logic [2:0] st_trail = 3'd4; // cs high gap after the frame

  logic                     ack_q;
  logic [15:0]              rdat_q;
  logic                     wb_hit;
  logic                     tx_load;
  logic                     start;
  logic                     busy;
  logic [div_width-1:0]     clkdiv;
  logic [div_width-1:0]     half_reload;
  logic [div_width-1:0]     half_cnt;
  logic                     half_tick;
  logic [2:0]               state;
  logic [bit_cnt_width-1:0] bit_cnt;
  logic                     trail_second;
  logic [1:0]               sample_pipe;
  logic [frame_width-1:0]   tx_word;
  logic [frame_width-1:0]   tx_shift;
  logic [frame_width-1:0]   rx_shift;
  logic [frame_width-1:0]   rxdata;

  ////////////////////////////////////////////////////////////////////////////
  // wishbone register block

  assign wb_hit  = wb_req.cyc & wb_req.stb & ~ack_q; // no wait states
  assign tx_load = wb_hit & wb_req.we & (wb_req.adr == reg_txdata) & ~busy & ~start;
  assign wb_rsp  = '{ack: ack_q, dat: rdat_q};

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      ack_q  <= 1'b0;
      start  <= 1'b0;
      clkdiv <= div_width'(clkdiv_reset);
    end else begin
      ack_q <= wb_hit;
      start <= tx_load; // FSM picks this up one cycle later
      if (wb_hit && wb_req.we && wb_req.adr == reg_clkdiv)
        clkdiv <= div_width'(wb_req.dat);
    end
  end

  always_ff @(posedge rst) begin
    if (wb_hit) begin
      case (wb_req.adr)
        reg_txdata: rdat_q <= '0;                // write only
        reg_rxdata: rdat_q <= rxdata;
        reg_status: rdat_q <= {{15{1'b0}}, busy};
        reg_clkdiv: rdat_q <= 16'(clkdiv);
      endcase
    end
    if (tx_load)
      tx_word <= wb_req.dat;
    // miso is taken two clocks after the fall, which covers the
    // slave's synchronizer delay even at a divider of 1
    if (sample_pipe[1])
      rx_shift <= {rx_shift[frame_width-2:0], miso};
  end

  ////////////////////////////////////////////////////////////////////////////
  // frame engine

  // divider of 0 behaves as 1
  assign half_reload = (clkdiv == '0) ? '0 : clkdiv - 1'b1;
  assign half_tick   = (half_cnt == '0);

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      state        <= st_idle;
      busy         <= 1'b0;
      spi          <= '{sclk: 1'b0, cs: 1'b1, mosi: 1'b0};
      half_cnt     <= '0;
      bit_cnt      <= '0;
      trail_second <= 1'b0;
      tx_shift     <= '0;
      sample_pipe  <= '0;
      rxdata       <= '0;
    end else begin
      sample_pipe <= {sample_pipe[0], 1'b0};
      if (state != st_idle)
        half_cnt <= half_tick ? half_reload : half_cnt - 1'b1;

      case (state)
        st_idle: begin
          if (start) begin
            spi.cs   <= 1'b0;
            tx_shift <= tx_word;
            half_cnt <= half_reload;
            bit_cnt  <= '0;
            busy     <= 1'b1;
            state    <= st_lead;
          end
        end
        st_lead: begin
          if (half_tick) begin
            spi.sclk <= 1'b1;
            spi.mosi <= tx_shift[frame_width-1]; // msb first
            state    <= st_high;
          end
        end
        st_high: begin
          if (half_tick) begin
            spi.sclk       <= 1'b0;
            tx_shift       <= {tx_shift[frame_width-2:0], 1'b0};
            bit_cnt        <= bit_cnt + 1'b1; // wraps after the last bit
            sample_pipe[0] <= 1'b1;
            state          <= st_low;
          end
        end
        st_low: begin
          if (half_tick) begin
            if (bit_cnt == '0) begin // all bits shifted
              spi.cs       <= 1'b1;
              spi.mosi     <= 1'b0;
              trail_second <= 1'b0;
              state        <= st_trail;
            end else begin
              spi.sclk <= 1'b1;
              spi.mosi <= tx_shift[frame_width-1];
              state    <= st_high;
            end
          end
        end
        st_trail: begin
          if (half_tick) begin
            if (trail_second) begin
              rxdata <= rx_shift;
              busy   <= 1'b0;
              state  <= st_idle;
            end else begin
              trail_second <= 1'b1;
            end
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

// ==== verilog/spi_link_pkg.sv ====
package spi_link_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // frame layout

  localparam int frame_width    = 16; // the union layout depends on this
  localparam int cmd_addr_width = 3;
  localparam int cmd_data_width = 12;

  typedef struct packed {
    logic                      write; // 1 = store data at addr
    logic [cmd_addr_width-1:0] addr;
    logic [cmd_data_width-1:0] data;
  } spi_cmd_t;

  // one word on the wire, seen either as bits or as a device command
  typedef union packed {
    logic [frame_width-1:0] raw;
    spi_cmd_t               cmd;
  } spi_frame_u;

  ////////////////////////////////////////////////////////////////////////////
  // host bus and spi lines

  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [1:0]  adr;
    logic [15:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic        ack;
    logic [15:0] dat;
  } wb_rsp_t;

  typedef struct packed {
    logic sclk;
    logic cs;   // active low
    logic mosi;
  } spi_bus_t;

  // host register map
  localparam logic [1:0] reg_txdata = 2'd0;
  localparam logic [1:0] reg_rxdata = 2'd1;
  localparam logic [1:0] reg_status = 2'd2;
  localparam logic [1:0] reg_clkdiv = 2'd3;

  localparam int clkdiv_reset = 4; // system cycles per sclk half period

endpackage
